// ==== rtl/atm_pkg.sv ====
`default_nettype none

package atm_pkg;

    localparam int NUM_DIGITS = 4;

    typedef logic [3:0] digit_t;               // 0..9 or blank
    typedef logic [13:0] bal_t;                // holds up to 9999
    typedef logic [6:0] seg_t;                 // active low with a in bit 6

    localparam digit_t DIGIT_BLANK = 4'd15;
    localparam bal_t BAL_MAX = 14'd9999;
    localparam bal_t RAPID_AMOUNT = 14'd100;

    typedef enum logic [1:0] {
        CMD_BALANCE,
        CMD_RAPID,
        CMD_WITHDRAW,
        CMD_DEPOSIT
    } cmd_t;

    typedef enum logic [2:0] {
        TXN_IDLE,
        TXN_BALANCE,
        TXN_RAPID,
        TXN_WITHDRAW,
        TXN_DEPOSIT
    } txn_state_t;

    localparam seg_t SEG_BLANK = 7'b1111111;

    // segment order is a b c d e f g
    localparam seg_t SEG_DIGITS [0:9] = '{
        7'b0000001,                            // 0
        7'b1001111,                            // 1
        7'b0010010,                            // 2
        7'b0000110,                            // 3
        7'b1001100,                            // 4
        7'b0100100,                            // 5
        7'b0100000,                            // 6
        7'b0001111,                            // 7
        7'b0000000,                            // 8
        7'b0000100                             // 9
    };

endpackage

`default_nettype wire

// ==== rtl/key_pulse.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_pulse (
    input  logic             clk_slow,
    input  logic             arst_n,
    input  logic [9:0]       digit_keys,
    input  logic             finish_btn,
    input  logic             balance_btn,
    input  logic             rapid_btn,
    input  logic             withdraw_btn,
    input  logic             deposit_btn,
    output logic             digit_stb,
    output atm_pkg::digit_t  digit_val,
    output logic             finish_stb,
    output logic             cmd_stb,
    output atm_pkg::cmd_t    cmd
);
    import atm_pkg::*;

    logic [9:0] keys_q;
    logic [3:0] btns_q;                        // deposit, withdraw, rapid, balance
    logic       finish_q;
    logic [9:0] key_rise;
    logic [3:0] btn_rise;
    digit_t     digit_next;
    cmd_t       cmd_next;

    always_comb
    begin
        key_rise = digit_keys & ~keys_q;
        btn_rise = {deposit_btn, withdraw_btn, rapid_btn, balance_btn} & ~btns_q;
        digit_next = '0;
        for (int i = 9; i >= 0; i--)
        begin
            if (key_rise[i])
            begin
                digit_next = digit_t'(i);      // last hit is the lowest key
            end
        end
        if (btn_rise[0])
            cmd_next = CMD_BALANCE;
        else if (btn_rise[1])
            cmd_next = CMD_RAPID;
        else if (btn_rise[2])
            cmd_next = CMD_WITHDRAW;
        else
            cmd_next = CMD_DEPOSIT;
    end

    always_ff @(posedge clk_slow or negedge arst_n)
    begin
        if (!arst_n)
        begin
            keys_q     <= '0;
            btns_q     <= '0;
            finish_q   <= 1'b0;
            digit_stb  <= 1'b0;
            finish_stb <= 1'b0;
            cmd_stb    <= 1'b0;
            digit_val  <= '0;
            cmd        <= CMD_BALANCE;
        end
        else
        begin
            keys_q     <= digit_keys;
            btns_q     <= {deposit_btn, withdraw_btn, rapid_btn, balance_btn};
            finish_q   <= finish_btn;
            digit_stb  <= |key_rise;
            finish_stb <= finish_btn & ~finish_q;
            cmd_stb    <= |btn_rise;
            digit_val  <= digit_next;
            cmd        <= cmd_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pin_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module pin_check #(
    parameter atm_pkg::digit_t [atm_pkg::NUM_DIGITS-1:0] PIN_CODE = '0
) (
    input  logic                                         clk_slow,
    input  logic                                         arst_n,
    input  logic                                         card_in,
    input  logic                                         digit_stb,
    input  atm_pkg::digit_t                              digit_val,
    input  logic                                         finish_stb,
    output logic                                         card_valid,
    output logic                                         card_invalid,
    output atm_pkg::digit_t [atm_pkg::NUM_DIGITS-1:0]    pin_digits
);
    import atm_pkg::*;

    localparam int CNT_W = $clog2(NUM_DIGITS + 1);
    localparam digit_t [NUM_DIGITS-1:0] ALL_BLANK = {NUM_DIGITS{DIGIT_BLANK}};

    logic [CNT_W-1:0]        count;            // digits entered so far
    logic                    accept;
    digit_t [NUM_DIGITS-1:0] digits_next;

    always_comb
    begin
        accept = digit_stb && !(card_valid || card_invalid) && (count < NUM_DIGITS);
        digits_next = pin_digits;
        if (accept)
        begin
            digits_next[NUM_DIGITS-1-count] = digit_val;   // fill from the left
        end
    end

    always_ff @(posedge clk_slow or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count        <= '0;
            card_valid   <= 1'b0;
            card_invalid <= 1'b0;
            pin_digits   <= ALL_BLANK;
        end
        else if (!card_in || finish_stb)
        begin
            count        <= '0;
            card_valid   <= 1'b0;
            card_invalid <= 1'b0;
            pin_digits   <= ALL_BLANK;
        end
        else if (accept)
        begin
            count      <= count + 1'b1;
            pin_digits <= digits_next;
            if (count == NUM_DIGITS - 1)
            begin
                card_valid   <= (digits_next == PIN_CODE);
                card_invalid <= (digits_next != PIN_CODE);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/transaction_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module transaction_ctrl #(
    parameter atm_pkg::bal_t INIT_BALANCE = 14'd99,
    parameter logic [31:0]   HOLD_CYCLES  = 32'd16383
) (
    input  logic                clk_slow,
    input  logic                arst_n,
    input  logic                card_valid,
    input  logic                cmd_stb,
    input  atm_pkg::cmd_t       cmd,
    input  logic                digit_stb,
    input  atm_pkg::digit_t     digit_val,
    input  logic                finish_stb,
    output atm_pkg::txn_state_t txn_state,
    output atm_pkg::bal_t       balance,
    output atm_pkg::bal_t       amount,
    output logic                green_led,
    output logic                red_led,
    output logic                cash_dispensed
);
    import atm_pkg::*;

    localparam int CNT_W = $clog2(NUM_DIGITS + 1);

    logic [CNT_W-1:0] num_keyed;               // amount digits so far
    logic [31:0]      hold_cnt;
    txn_state_t       cmd_state;
    logic             complete;
    logic             pay_out;
    logic             funds_ok;
    logic             entry;
    bal_t             sum;
    logic [14:0]      dep_sum;

    function automatic txn_state_t cmd_to_state(input cmd_t c);
        case (c)
            CMD_BALANCE:  return TXN_BALANCE;
            CMD_RAPID:    return TXN_RAPID;
            CMD_WITHDRAW: return TXN_WITHDRAW;
            default:      return TXN_DEPOSIT;
        endcase
    endfunction

    always_comb
    begin
        cmd_state = cmd_to_state(cmd);
        complete  = card_valid && cmd_stb && (cmd_state == txn_state);  // same command twice
        entry     = (txn_state == TXN_WITHDRAW) || (txn_state == TXN_DEPOSIT);
        sum       = (txn_state == TXN_RAPID) ? RAPID_AMOUNT : amount;
        funds_ok  = (balance >= sum);
        pay_out   = complete && ((txn_state == TXN_RAPID) || (txn_state == TXN_WITHDRAW));
        dep_sum   = {1'b0, balance} + {1'b0, amount};
    end

    always_ff @(posedge clk_slow or negedge arst_n)
    begin
        if (!arst_n)
        begin
            txn_state <= TXN_IDLE;
            balance   <= INIT_BALANCE;
            amount    <= '0;
            num_keyed <= '0;
        end
        else if (!card_valid || finish_stb)
        begin
            txn_state <= TXN_IDLE;
            amount    <= '0;
            num_keyed <= '0;
        end
        else if (cmd_stb)
        begin
            amount    <= '0;
            num_keyed <= '0;
            if (complete)
            begin
                txn_state <= TXN_IDLE;
                if (pay_out && funds_ok)
                    balance <= balance - sum;
                else if (txn_state == TXN_DEPOSIT)
                    balance <= (dep_sum > BAL_MAX) ? BAL_MAX : dep_sum[13:0];  // saturate
            end
            else
            begin
                txn_state <= cmd_state;
            end
        end
        else if (digit_stb && entry && (num_keyed < NUM_DIGITS))
        begin
            amount    <= amount * bal_t'(10) + bal_t'(digit_val);
            num_keyed <= num_keyed + 1'b1;
        end
    end

    // outcome LEDs and their hold timer
    always_ff @(posedge clk_slow or negedge arst_n)
    begin
        if (!arst_n)
        begin
            green_led      <= 1'b0;
            red_led        <= 1'b0;
            cash_dispensed <= 1'b0;
            hold_cnt       <= '0;
        end
        else if (finish_stb)
        begin
            green_led      <= 1'b0;
            red_led        <= 1'b0;
            cash_dispensed <= 1'b0;
            hold_cnt       <= '0;
        end
        else if (pay_out)
        begin
            green_led      <= funds_ok;
            cash_dispensed <= funds_ok;
            red_led        <= !funds_ok;
            hold_cnt       <= '0;             // restart hold
        end
        else if (green_led || red_led || cash_dispensed)
        begin
            if (hold_cnt == HOLD_CYCLES - 1)
            begin
                green_led      <= 1'b0;
                red_led        <= 1'b0;
                cash_dispensed <= 1'b0;
                hold_cnt       <= '0;
            end
            else
            begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/display_out.sv ====
`timescale 1ns/100ps
`default_nettype none

module display_out (
    input  atm_pkg::txn_state_t                       txn_state,
    input  atm_pkg::bal_t                             balance,
    input  atm_pkg::bal_t                             amount,
    input  atm_pkg::digit_t [atm_pkg::NUM_DIGITS-1:0] pin_digits,
    output atm_pkg::seg_t                             seg3,
    output atm_pkg::seg_t                             seg2,
    output atm_pkg::seg_t                             seg1,
    output atm_pkg::seg_t                             seg0
);
    import atm_pkg::*;

    bal_t                    value;
    digit_t [NUM_DIGITS-1:0] digits;

    function automatic seg_t seg_encode(input digit_t d);
        if (d <= 4'd9)
            return SEG_DIGITS[d];
        else
            return SEG_BLANK;                  // blank and unused codes
    endfunction

    always_comb
    begin
        case (txn_state)
            TXN_BALANCE:  value = balance;
            TXN_RAPID:    value = RAPID_AMOUNT;
            default:      value = amount;
        endcase
        if (txn_state == TXN_IDLE)
        begin
            digits = pin_digits;
        end
        else
        begin
            digits[3] = digit_t'((value / 14'd1000) % 14'd10);
            digits[2] = digit_t'((value / 14'd100) % 14'd10);
            digits[1] = digit_t'((value / 14'd10) % 14'd10);
            digits[0] = digit_t'(value % 14'd10);
        end
    end

    assign seg3 = seg_encode(digits[3]);
    assign seg2 = seg_encode(digits[2]);
    assign seg1 = seg_encode(digits[1]);
    assign seg0 = seg_encode(digits[0]);

endmodule

`default_nettype wire

// ==== rtl/atm_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module atm_top #(
    parameter atm_pkg::digit_t [atm_pkg::NUM_DIGITS-1:0] PIN_CODE     = '0,
    parameter atm_pkg::bal_t                             INIT_BALANCE = 14'd99,
    parameter logic [31:0]                               HOLD_CYCLES  = 32'd16383
) (
    input  logic          clk_slow,
    input  logic          arst_n,
    input  logic          card_in,
    input  logic [9:0]    digit_keys,
    input  logic          finish_btn,
    input  logic          balance_btn,
    input  logic          rapid_btn,
    input  logic          withdraw_btn,
    input  logic          deposit_btn,
    output logic          card_valid,
    output logic          card_invalid,
    output logic          green_led,
    output logic          red_led,
    output logic          cash_dispensed,
    output atm_pkg::seg_t seg3,
    output atm_pkg::seg_t seg2,
    output atm_pkg::seg_t seg1,
    output atm_pkg::seg_t seg0
);
    import atm_pkg::*;

    logic                    digit_stb;
    digit_t                  digit_val;
    logic                    finish_stb;
    logic                    cmd_stb;
    cmd_t                    cmd;
    digit_t [NUM_DIGITS-1:0] pin_digits;
    txn_state_t              txn_state;
    bal_t                    balance;
    bal_t                    amount;

    key_pulse u_key_pulse (
        .clk_slow(clk_slow), .arst_n(arst_n), .digit_keys(digit_keys),
        .finish_btn(finish_btn), .balance_btn(balance_btn), .rapid_btn(rapid_btn),
        .withdraw_btn(withdraw_btn), .deposit_btn(deposit_btn),
        .digit_stb(digit_stb), .digit_val(digit_val), .finish_stb(finish_stb),
        .cmd_stb(cmd_stb), .cmd(cmd)
    );

    pin_check #(.PIN_CODE(PIN_CODE)) u_pin_check (
        .clk_slow(clk_slow), .arst_n(arst_n), .card_in(card_in),
        .digit_stb(digit_stb), .digit_val(digit_val), .finish_stb(finish_stb),
        .card_valid(card_valid), .card_invalid(card_invalid), .pin_digits(pin_digits)
    );

    transaction_ctrl #(.INIT_BALANCE(INIT_BALANCE), .HOLD_CYCLES(HOLD_CYCLES)) u_txn (
        .clk_slow(clk_slow), .arst_n(arst_n), .card_valid(card_valid),
        .cmd_stb(cmd_stb), .cmd(cmd), .digit_stb(digit_stb), .digit_val(digit_val),
        .finish_stb(finish_stb), .txn_state(txn_state), .balance(balance),
        .amount(amount), .green_led(green_led), .red_led(red_led),
        .cash_dispensed(cash_dispensed)
    );

    display_out u_display (
        .txn_state(txn_state), .balance(balance), .amount(amount),
        .pin_digits(pin_digits), .seg3(seg3), .seg2(seg2), .seg1(seg1), .seg0(seg0)
    );

endmodule

`default_nettype wire

// ==== test/tb_atm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_atm;

    localparam int MAX_STEPS    = 128;
    localparam int RESET_CYCLES = 8;

    logic       clk_slow;
    logic       arst_n;
    logic       card_in;
    logic [9:0] digit_keys;
    logic       finish_btn;
    logic       balance_btn;
    logic       rapid_btn;
    logic       withdraw_btn;
    logic       deposit_btn;
    logic       card_valid;
    logic       card_invalid;
    logic       green_led;
    logic       red_led;
    logic       cash_dispensed;
    logic [6:0] seg3;
    logic [6:0] seg2;
    logic [6:0] seg1;
    logic [6:0] seg0;

    logic [8*16-1:0] step_name [MAX_STEPS];
    logic [8*8-1:0]  step_op   [MAX_STEPS];
    logic [8*8-1:0]  step_btn  [MAX_STEPS];
    int              step_arg  [MAX_STEPS][9];
    int num_steps    = 0;
    int wait_total   = 0;
    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_limit  = 0;                      // zero until the test file is read
    int cycle_count  = 0;

    atm_top #(
        .PIN_CODE(16'h1234),
        .INIT_BALANCE(14'd99),
        .HOLD_CYCLES(32'd40)
    ) DUT (
        .clk_slow(clk_slow), .arst_n(arst_n), .card_in(card_in), .digit_keys(digit_keys),
        .finish_btn(finish_btn), .balance_btn(balance_btn), .rapid_btn(rapid_btn),
        .withdraw_btn(withdraw_btn), .deposit_btn(deposit_btn),
        .card_valid(card_valid), .card_invalid(card_invalid), .green_led(green_led),
        .red_led(red_led), .cash_dispensed(cash_dispensed),
        .seg3(seg3), .seg2(seg2), .seg1(seg1), .seg0(seg0)
    );

    initial
    begin
        clk_slow = 1'b0;
        forever #5 clk_slow = ~clk_slow;
    end

    always @(posedge clk_slow)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // active low with segment a in bit 6
    function automatic int decode_seg(input logic [6:0] seg);
        case (seg)
            7'b0000001: return 0;
            7'b1001111: return 1;
            7'b0010010: return 2;
            7'b0000110: return 3;
            7'b1001100: return 4;
            7'b0100100: return 5;
            7'b0100000: return 6;
            7'b0001111: return 7;
            7'b0000000: return 8;
            7'b0000100: return 9;
            7'b1111111: return 15;             // blank
            default:    return 99;
        endcase
    endfunction

    task automatic load_tests();
        int               fd;
        int               n;
        int               a [9];
        logic             done;
        logic [8*16-1:0]  name;
        logic [8*8-1:0]   op;
        logic [8*8-1:0]   btn;
        logic [8*120-1:0] rest;
        done = 1'b0;
        fd = $fopen("test/atm_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/atm_tests.txt");
            errors++;
            done = 1'b1;
        end
        while (!done && num_steps < MAX_STEPS)
        begin
            for (int k = 0; k < 9; k++)
                a[k] = 0;
            n = $fscanf(fd, "%s", name);
            if (n != 1)
                done = 1'b1;
            else if (name == "#")
                n = $fgets(rest, fd);          // column notes
            else
            begin
                n = $fscanf(fd, "%s", op);
                if (op == "button")
                    n = $fscanf(fd, "%s", btn);
                else if (op == "check")
                    n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                                a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8]);
                else if (op == "card" || op == "key" || op == "wait")
                    n = $fscanf(fd, "%d", a[0]);
                else
                begin
                    $display("test file holds an unknown operation in %0s", name);
                    errors++;
                    n = $fgets(rest, fd);
                end
                if (op == "wait")
                    wait_total += a[0];
                step_name[num_steps] = name;
                step_op[num_steps]   = op;
                step_btn[num_steps]  = btn;
                for (int k = 0; k < 9; k++)
                    step_arg[num_steps][k] = a[k];
                num_steps++;
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    task automatic next_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk_slow);
            #2;                                // drive away from the edge
        end
    endtask

    task automatic set_button(input logic [8*8-1:0] btn, input logic level,
                              output logic known);
        known = 1'b1;
        case (btn)
            "finish":   finish_btn = level;
            "balance":  balance_btn = level;
            "rapid":    rapid_btn = level;
            "withdraw": withdraw_btn = level;
            "deposit":  deposit_btn = level;
            default:    known = 1'b0;
        endcase
    endtask

    task automatic press_button(input logic [8*16-1:0] test, input logic [8*8-1:0] btn);
        logic known;
        set_button(btn, 1'b1, known);
        if (!known)
        begin
            $display("%0s: button name in the test file is not recognized", test);
            test_errors++;
            errors++;
        end
        next_cycles(2);
        set_button(btn, 1'b0, known);
        next_cycles(2);
    endtask

    task automatic press_key(input int digit);
        digit_keys[digit] = 1'b1;
        next_cycles(2);
        digit_keys = '0;
        next_cycles(2);
    endtask

    task automatic check_value(input logic [8*16-1:0] test, input logic [8*8-1:0] what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                     test, what, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic check_outputs(input int i);
        logic [8*16-1:0] t;
        t = step_name[i];
        check_value(t, "green", step_arg[i][0], {31'd0, green_led});
        check_value(t, "red", step_arg[i][1], {31'd0, red_led});
        check_value(t, "cash", step_arg[i][2], {31'd0, cash_dispensed});
        check_value(t, "valid", step_arg[i][3], {31'd0, card_valid});
        check_value(t, "invalid", step_arg[i][4], {31'd0, card_invalid});
        check_value(t, "digit3", step_arg[i][5], decode_seg(seg3));
        check_value(t, "digit2", step_arg[i][6], decode_seg(seg2));
        check_value(t, "digit1", step_arg[i][7], decode_seg(seg1));
        check_value(t, "digit0", step_arg[i][8], decode_seg(seg0));
    endtask

    task automatic run_step(input int i);
        if (step_op[i] == "card")
        begin
            card_in = (step_arg[i][0] != 0);
            next_cycles(2);
        end
        else if (step_op[i] == "key")
            press_key(step_arg[i][0]);
        else if (step_op[i] == "button")
            press_button(step_name[i], step_btn[i]);
        else if (step_op[i] == "wait")
            next_cycles(step_arg[i][0]);
        else if (step_op[i] == "check")
            check_outputs(i);
    endtask

    task automatic report_test(input logic [8*16-1:0] test);
        tests_run++;
        if (test_errors == 0)
            $display("test %0s: passed", test);
        else
        begin
            $display("test %0s: failed with %0d errors", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial
    begin
        arst_n       = 1'b0;
        card_in      = 1'b0;
        digit_keys   = '0;
        finish_btn   = 1'b0;
        balance_btn  = 1'b0;
        rapid_btn    = 1'b0;
        withdraw_btn = 1'b0;
        deposit_btn  = 1'b0;
        load_tests();
        cycle_limit = num_steps * 8 + wait_total + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk_slow);
        #2 arst_n = 1'b1;
        for (int i = 0; i < num_steps; i++)
        begin
            if (i > 0 && step_name[i] != step_name[i-1])
                report_test(step_name[i-1]);
            run_step(i);
        end
        if (num_steps > 0)
            report_test(step_name[num_steps-1]);
        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== atm.f ====
rtl/atm_pkg.sv
rtl/key_pulse.sv
rtl/pin_check.sv
rtl/transaction_ctrl.sv
rtl/display_out.sv
rtl/atm_top.sv
test/tb_atm.sv

// ==== Bender.yml ====
package:
  name: atm

sources:
  - rtl/atm_pkg.sv
  - rtl/key_pulse.sv
  - rtl/pin_check.sv
  - rtl/transaction_ctrl.sv
  - rtl/display_out.sv
  - rtl/atm_top.sv
  - target: test
    files:
      - test/tb_atm.sv

// ==== test/atm_tests.txt ====
# test op args: card <level> | key <digit> | button <name> | wait <cycles>
# check <green> <red> <cash> <valid> <invalid> <d3> <d2> <d1> <d0>, digit 15 is blank
wrong_pin card 1
wrong_pin key 1
wrong_pin key 2
wrong_pin key 3
wrong_pin key 5
wrong_pin check 0 0 0 0 1 1 2 3 5
wrong_pin card 0
wrong_pin check 0 0 0 0 0 15 15 15 15
correct_pin card 1
correct_pin key 1
correct_pin key 2
correct_pin key 3
correct_pin key 4
correct_pin check 0 0 0 1 0 1 2 3 4
correct_pin button balance
correct_pin check 0 0 0 1 0 0 0 9 9
correct_pin button balance
correct_pin check 0 0 0 1 0 1 2 3 4
deposit button deposit
deposit key 2
deposit key 5
deposit key 0
deposit check 0 0 0 1 0 0 2 5 0
deposit button deposit
deposit button balance
deposit check 0 0 0 1 0 0 3 4 9
deposit button balance
withdraw button withdraw
withdraw key 3
withdraw key 5
withdraw key 0
withdraw button withdraw
withdraw button balance
withdraw check 0 1 0 1 0 0 3 4 9
withdraw button balance
withdraw button withdraw
withdraw key 4
withdraw key 9
withdraw button withdraw
withdraw button balance
withdraw check 1 0 1 1 0 0 3 0 0
withdraw button balance
rapid button rapid
rapid check 1 0 1 1 0 0 1 0 0
rapid button rapid
rapid check 1 0 1 1 0 1 2 3 4
rapid button withdraw
rapid key 1
rapid key 5
rapid key 0
rapid button withdraw
rapid button rapid
rapid button rapid
rapid button balance
rapid check 0 1 0 1 0 0 0 5 0
rapid button balance
hold_timer wait 45
hold_timer check 0 0 0 1 0 1 2 3 4
saturate button deposit
saturate key 9
saturate key 9
saturate key 9
saturate key 9
saturate button deposit
saturate button balance
saturate check 0 0 0 1 0 9 9 9 9
saturate button balance
finish button rapid
finish button rapid
finish check 1 0 1 1 0 1 2 3 4
finish button finish
finish check 0 0 0 0 0 15 15 15 15
